//--- sources.f
+incdir+src
src/watchPkg.sv
src/displayPkg.sv
src/watchIf.sv
src/keyDebounce.sv
src/modeControl.sv
src/timeKeeper.sv
src/alarmUnit.sv
src/displayDriver.sv
src/watchTop.sv
test/watchTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module watchTb -o watchSim
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

out=$(./obj_dir/watchSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

//--- test/watchTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "watch_settings.svh"

module watchTb;
	localparam int tps = `WATCH_TICKS_PER_SEC;

	logic clk = 1'b0;
	logic rst, modeBtn, selectBtn, adjustBtn;
	logic [7:0] seg, digit, led;
	logic beep;
	logic [7:0] lastSeg, lastDigit, lastLed;
	logic lastBeep;
	int seed = 32'he0e;
	int cyc, errs, tests, mark;
	int mMode, mField, h, m, s, ah, am, as, ringLeft, quiet, beepSeen;

	watchTop u_dut (.clk, .rst, .modeBtn, .selectBtn, .adjustBtn, .seg, .digit, .led, .beep);

	always #50 clk = ~clk;

	task automatic reportTimeout(input string why);
		$display("%s at %0t", why, $time);
		errs++;
	endtask

	task automatic tickModel();
		if ((h == ah && m == am && s == as) || (m == 59 && s == 59 && mField == 0)) begin
			ringLeft = `WATCH_RING_SECONDS; // match or full hour
		end else if (ringLeft > 0) begin
			ringLeft--;
		end
		s = (s + 1) % 60;
		if (s == 0) begin
			m = (m + 1) % 60;
			if (m == 0) h = (h + 1) % 24;
		end
	endtask

	// sample at negedge and return on the rising edge
	task automatic step();
		@(negedge clk);
		lastSeg = seg;
		lastDigit = digit;
		lastLed = led;
		lastBeep = beep;
		if (lastBeep) beepSeen = 1;
		if (quiet >= 3) begin
			assert (lastBeep == 1'b0) else begin
				$display("** Error at %0t: beep expected 0, got %b", $time, lastBeep);
				errs++;
			end
		end
		@(posedge clk);
		cyc++;
		if (cyc % tps == 1 && cyc > 1) tickModel();
		quiet = (ringLeft > 0) ? 0 : quiet + 1;
	endtask

	task automatic waitSteps(input int n);
		for (int i = 0; i < n; i++) step();
	endtask

	task automatic applyPress(input int which);
		if (which == 0) begin
			mMode = 1 - mMode;
			mField = 0;
		end else if (which == 1) begin
			mField = (mField + 1) % 4;
		end else if (mField != 0 && mMode == 0) begin
			if (mField == 1) s = 0;
			if (mField == 2) m = (m + 1) % 60;
			if (mField == 3) h = (h + 1) % 24;
		end else if (mField != 0) begin
			if (mField == 1) as = (as + 1) % 60;
			if (mField == 2) am = (am + 1) % 60;
			if (mField == 3) ah = (ah + 1) % 24;
		end
	endtask

	// which is mode (0), select (1) or adjust (2)
	task automatic press(input int which);
		while (cyc % tps >= 12 && cyc % tps <= 16) step(); // keep clear of a second tick
		modeBtn <= (which == 0);
		selectBtn <= (which == 1);
		adjustBtn <= (which == 2);
		waitSteps(`WATCH_DEBOUNCE_TICKS + 2);
		modeBtn <= 1'b0;
		selectBtn <= 1'b0;
		adjustBtn <= 1'b0;
		step();
		applyPress(which); // effect lands 7 cycles after the drive
		waitSteps(`WATCH_DEBOUNCE_TICKS + 1);
	endtask

	function automatic int pairOf(input int f);
		if (f == 1) return (mMode == 0) ? s : as;
		if (f == 2) return (mMode == 0) ? m : am;
		return (mMode == 0) ? h : ah;
	endfunction

	task automatic selectTo(input int f);
		for (int n = 0; n < 4 && mField != f; n++) press(1);
	endtask

	task automatic tuneTo(input int f, input int want);
		int n;
		selectTo(f);
		if (f == 1 && mMode == 0) begin
			press(2); // seconds only clear
		end else begin
			for (n = 0; n < 80 && pairOf(f) != want; n++) press(2);
			if (n == 80) reportTimeout("field never reached its target value");
		end
	endtask

	function automatic logic [7:0] expectSeg(input int p);
		int hh, mm, ss;
		hh = (mMode == 0) ? h : ah;
		mm = (mMode == 0) ? m : am;
		ss = (mMode == 0) ? s : as;
		case (p)
			0: return displayPkg::segDigits[ss % 10];
			1: return displayPkg::segDigits[ss / 10];
			3: return displayPkg::segDigits[mm % 10];
			4: return displayPkg::segDigits[mm / 10];
			6: return displayPkg::segDigits[hh % 10];
			7: return displayPkg::segDigits[hh / 10];
			default: return displayPkg::segDash;
		endcase
	endfunction

	task automatic checkDisplay();
		int n;
		for (n = 0; n < 2 * tps && cyc % tps != 3; n++) step();
		for (int p = 0; p < 8; p++) begin
			for (n = 0; n < 20 && lastDigit != ~(8'b1 << p); n++) step();
			if (n == 20) begin
				reportTimeout("digit scan did not reach the next position");
				return;
			end
			assert (lastSeg == expectSeg(p)) else begin
				$display("** Error at %0t: seg[%0d] expected %h, got %h", $time, p,
					expectSeg(p), lastSeg);
				errs++;
			end
			step();
		end
	endtask

	task automatic checkBlink();
		int sawBlank, sawShown, base;
		sawBlank = 0;
		sawShown = 0;
		base = (mField - 1) * 3;
		for (int i = 0; i < 4 * `WATCH_BLINK_TICKS; i++) begin
			step();
			if (lastDigit == ~(8'b1 << base) || lastDigit == ~(8'b1 << (base + 1))) begin
				if (lastSeg == displayPkg::segBlank) sawBlank = 1;
				else sawShown = 1;
			end
		end
		assert (sawBlank == 1 && sawShown == 1) else begin
			$display("selected field did not blink at %0t", $time);
			errs++;
		end
	endtask

	task automatic finishTest(input string name);
		tests++;
		$display("%s: %0d errors", name, errs - mark);
		mark = errs;
	endtask

	function automatic int pickRandom(input int range);
		int r;
		r = $random(seed);
		if (r < 0) r = -r;
		return r % range;
	endfunction

	initial begin
		int target;
		rst = 1'b1;
		modeBtn = 1'b0;
		selectBtn = 1'b0;
		adjustBtn = 1'b0;
		{mMode, mField, h, m, s, ah, am, as, ringLeft, quiet, beepSeen} = '0;
		{cyc, errs, tests, mark} = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		cyc = 0;

		step();
		assert (lastLed == 8'hfe) else begin
			$display("** Error at %0t: led expected fe, got %h", $time, lastLed);
			errs++;
		end
		assert (lastBeep == 1'b0) else begin
			$display("** Error at %0t: beep expected 0, got %b", $time, lastBeep);
			errs++;
		end
		checkDisplay();
		finishTest("reset state");

		waitSteps(tps * (3 + pickRandom(8)));
		checkDisplay();
		tuneTo(3, 23);
		tuneTo(1, 0);
		tuneTo(2, 59);
		selectTo(0);
		for (int n = 0; n < 70 * tps && h != 0; n++) step();
		waitSteps(tps * (1 + pickRandom(4)));
		checkDisplay();
		finishTest("time runs and rolls over");

		for (int i = 0; i < 8; i++) press(1 + pickRandom(2));
		if (mField == 0) press(1);
		checkBlink();
		selectTo(0);
		checkDisplay();
		finishTest("time setting");

		press(0);
		step();
		assert (lastLed == 8'hfd) else begin
			$display("** Error at %0t: led expected fd, got %h", $time, lastLed);
			errs++;
		end
		for (int i = 0; i < 10; i++) press(1 + pickRandom(2));
		selectTo(0);
		checkDisplay();
		finishTest("alarm mode");

		target = ((h * 3600 + m * 60 + s) / 60 + 4) % 1440; // minutes of day
		tuneTo(1, 0);
		tuneTo(2, target % 60);
		tuneTo(3, target / 60);
		selectTo(0);
		press(0);
		for (int n = 0; n < 300 * tps && !(h == ah && m == am && s == as); n++) step();
		beepSeen = 0;
		for (int n = 0; n < 3 * tps && ringLeft == 0; n++) step();
		waitSteps(tps);
		assert (beepSeen == 1) else begin
			$display("beep did not sound after the alarm match at %0t", $time);
			errs++;
		end
		waitSteps((`WATCH_RING_SECONDS + 2) * tps);
		finishTest("alarm ring");

		tuneTo(1, 0);
		tuneTo(2, 59);
		selectTo(0);
		beepSeen = 0;
		for (int n = 0; n < 70 * tps && m != 0; n++) step();
		waitSteps(2 * tps);
		assert (beepSeen == 1) else begin
			$display("no chime at the full hour at %0t", $time);
			errs++;
		end
		finishTest("hourly chime");

		$display("%0d tests, %0d errors", tests, errs);
		if (errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

//--- src/watchTop.sv
`timescale 1ns/1ns
`default_nettype none

module watchTop (
	input logic clk,
	input logic rst,
	input logic modeBtn,
	input logic selectBtn,
	input logic adjustBtn,
	output logic [7:0] seg,
	output logic [7:0] digit,
	output logic [7:0] led,
	output logic beep
);
	logic chime; // full hour pulse

	watchIf bus ();

	modeControl modeCtl (
		.clk,
		.rst,
		.modeBtn,
		.selectBtn,
		.adjustBtn,
		.ctl(bus.control)
	);

	timeKeeper keeper (.clk, .rst, .tk(bus.keeper), .chime);

	alarmUnit alarmBlk (.clk, .rst, .chime, .al(bus.alarm), .beep);

	displayDriver display (.clk, .rst, .vw(bus.view), .seg, .digit, .led);
endmodule

`default_nettype wire

//--- src/displayDriver.sv
`timescale 1ns/1ns
`default_nettype none
`include "watch_settings.svh"

module displayDriver (
	input logic clk,
	input logic rst,
	watchIf.view vw,
	output logic [7:0] seg,
	output logic [7:0] digit,
	output logic [7:0] led
);
	localparam int scanWidth = $clog2(`WATCH_SCAN_TICKS + 1);
	localparam int blinkWidth = $clog2(`WATCH_BLINK_TICKS + 1);

	logic [scanWidth-1:0] scanCnt;
	logic [blinkWidth-1:0] blinkCnt;
	logic blinkOn;
	logic [2:0] pos;
	logic [2:0] nibble;
	watchPkg::bcdTime shown;
	watchPkg::bcdDigit value;
	watchPkg::setField posField;
	displayPkg::segPattern segNext;

	always_comb begin
		shown = (vw.mode == watchPkg::modeAlarm) ? vw.alarmTime : vw.timeNow;
		nibble = pos - {2'b0, pos >= 3'd3} - {2'b0, pos >= 3'd6}; // skip the dash positions
		value = shown[4*nibble +: 4];
		posField = (pos < 3'd2) ? watchPkg::fieldSec :
			(pos < 3'd5) ? watchPkg::fieldMin : watchPkg::fieldHour;
		if (pos == 3'd2 || pos == 3'd5) begin
			segNext = displayPkg::segDash;
		end else if (blinkOn && (posField == vw.field)) begin
			segNext = displayPkg::segBlank;
		end else if (value > 4'd9) begin
			segNext = displayPkg::segBlank;
		end else begin
			segNext = displayPkg::segDigits[value];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			scanCnt <= '0;
			blinkCnt <= '0;
			blinkOn <= 1'b0;
			pos <= '0;
			seg <= displayPkg::segBlank;
			digit <= displayPkg::digitOff;
		end else begin
			if (blinkCnt == blinkWidth'(`WATCH_BLINK_TICKS - 1)) begin
				blinkCnt <= '0;
				blinkOn <= ~blinkOn;
			end else begin
				blinkCnt <= blinkCnt + 1'b1;
			end
			if (scanCnt == scanWidth'(`WATCH_SCAN_TICKS - 1)) begin
				scanCnt <= '0;
				pos <= pos + 3'd1;
				seg <= segNext;
				digit <= ~(8'b1 << pos);
			end else begin
				scanCnt <= scanCnt + 1'b1;
			end
		end
	end

	assign led = (vw.mode == watchPkg::modeAlarm) ? displayPkg::ledAlarm : displayPkg::ledTime;

	oneDigitLit: assert property (@(posedge clk) disable iff (rst) $onehot0(~digit));
endmodule

`default_nettype wire

//--- src/alarmUnit.sv
`timescale 1ns/1ns
`default_nettype none
`include "watch_settings.svh"

module alarmUnit (
	input logic clk,
	input logic rst,
	input logic chime,
	watchIf.alarm al,
	output logic beep
);
	localparam int ringWidth = $clog2(`WATCH_RING_SECONDS + 1);
	localparam int phaseLen = `WATCH_TONE_TICKS + `WATCH_GAP_TICKS;
	localparam int phaseWidth = $clog2(phaseLen + 1);

	watchPkg::bcdTime alarm;
	watchPkg::bcdTime nextAlarm;
	logic [ringWidth-1:0] ringCnt;
	logic [phaseWidth-1:0] phase;
	logic trigger;
	logic ringing;

	assign trigger = chime || (al.secTick && (al.timeNow == alarm));
	assign ringing = ringCnt != '0;

	always_comb begin
		nextAlarm = alarm;
		if (al.adjust && (al.mode == watchPkg::modeAlarm)) begin
			case (al.field)
				watchPkg::fieldSec: begin
					{nextAlarm.secTens, nextAlarm.secOnes} =
						watchPkg::incSixty({alarm.secTens, alarm.secOnes});
				end
				watchPkg::fieldMin: begin
					{nextAlarm.minTens, nextAlarm.minOnes} =
						watchPkg::incSixty({alarm.minTens, alarm.minOnes});
				end
				watchPkg::fieldHour: begin
					{nextAlarm.hourTens, nextAlarm.hourOnes} =
						watchPkg::incHour({alarm.hourTens, alarm.hourOnes});
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			alarm <= '0;
			ringCnt <= '0;
			phase <= '0;
			beep <= 1'b0;
		end else begin
			alarm <= nextAlarm;
			if (trigger) begin
				ringCnt <= ringWidth'(`WATCH_RING_SECONDS); // retrigger restarts the ring
			end else if (al.secTick && ringing) begin
				ringCnt <= ringCnt - 1'b1;
			end
			if (!ringing) begin
				phase <= '0;
				beep <= 1'b0;
			end else begin
				phase <= (phase == phaseWidth'(phaseLen - 1)) ? '0 : phase + 1'b1;
				beep <= (phase < phaseWidth'(`WATCH_TONE_TICKS)) ? ~beep : 1'b0; // tone, then gap
			end
		end
	end

	assign al.alarmTime = alarm;

	quietWhenIdle: assert property (@(posedge clk) disable iff (rst) !ringing |=> !beep);
endmodule

`default_nettype wire

//--- src/timeKeeper.sv
`timescale 1ns/1ns
`default_nettype none
`include "watch_settings.svh"

module timeKeeper (
	input logic clk,
	input logic rst,
	watchIf.keeper tk,
	output logic chime
);
	localparam int divWidth = $clog2(`WATCH_TICKS_PER_SEC + 1);

	logic [divWidth-1:0] divCnt;
	logic secEdge;
	logic secTick;
	logic timeAdjust;
	watchPkg::bcdTime now;
	watchPkg::bcdTime nextTime;

	assign secEdge = divCnt == divWidth'(`WATCH_TICKS_PER_SEC - 1);
	assign timeAdjust = tk.adjust && (tk.mode == watchPkg::modeTime);

	always_comb begin
		nextTime = now;
		if (timeAdjust) begin
			case (tk.field)
				watchPkg::fieldSec: {nextTime.secTens, nextTime.secOnes} = 8'h00;
				watchPkg::fieldMin: begin
					{nextTime.minTens, nextTime.minOnes} =
						watchPkg::incSixty({now.minTens, now.minOnes}); // no carry into hours
				end
				watchPkg::fieldHour: begin
					{nextTime.hourTens, nextTime.hourOnes} =
						watchPkg::incHour({now.hourTens, now.hourOnes});
				end
				default: ;
			endcase
		end else if (secTick) begin
			{nextTime.secTens, nextTime.secOnes} = watchPkg::incSixty({now.secTens, now.secOnes});
			if ({now.secTens, now.secOnes} == 8'h59) begin
				{nextTime.minTens, nextTime.minOnes} =
					watchPkg::incSixty({now.minTens, now.minOnes});
				if ({now.minTens, now.minOnes} == 8'h59) begin
					{nextTime.hourTens, nextTime.hourOnes} =
						watchPkg::incHour({now.hourTens, now.hourOnes});
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			divCnt <= '0;
			secTick <= 1'b0;
			chime <= 1'b0;
			now <= '0;
		end else begin
			divCnt <= secEdge ? '0 : divCnt + 1'b1;
			secTick <= secEdge;
			// fires with the tick that rolls mm:ss over to 00:00
			chime <= secEdge && (tk.field == watchPkg::fieldNone) &&
				({now.minTens, now.minOnes, now.secTens, now.secOnes} == 16'h5959);
			now <= nextTime;
		end
	end

	assign tk.timeNow = now;
	assign tk.secTick = secTick;

	digitsInRange: assert property (@(posedge clk) disable iff (rst)
		now.secOnes <= 4'd9 && now.secTens <= 4'd5 && now.minOnes <= 4'd9 &&
		now.minTens <= 4'd5 && now.hourOnes <= 4'd9 && {now.hourTens, now.hourOnes} <= 8'h23);
endmodule

`default_nettype wire

//--- src/modeControl.sv
`timescale 1ns/1ns
`default_nettype none

module modeControl (
	input logic clk,
	input logic rst,
	input logic modeBtn,
	input logic selectBtn,
	input logic adjustBtn,
	watchIf.control ctl
);
	logic modePress;
	logic selectPress;
	logic adjustPress;
	watchPkg::watchMode mode;
	watchPkg::setField field;
	watchPkg::setField fieldNext;
	logic adjust;

	keyDebounce modeKey (.clk, .rst, .key(modeBtn), .press(modePress));
	keyDebounce selectKey (.clk, .rst, .key(selectBtn), .press(selectPress));
	keyDebounce adjustKey (.clk, .rst, .key(adjustBtn), .press(adjustPress));

	always_comb begin
		fieldNext = field;
		if (modePress) begin
			fieldNext = watchPkg::fieldNone; // leaving a mode ends setting
		end else if (selectPress) begin
			fieldNext = watchPkg::setField'(field + 2'd1); // none, sec, min, hour, none
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= watchPkg::modeTime;
			field <= watchPkg::fieldNone;
			adjust <= 1'b0;
		end else begin
			if (modePress) begin
				mode <= (mode == watchPkg::modeTime) ? watchPkg::modeAlarm : watchPkg::modeTime;
			end
			field <= fieldNext;
			adjust <= adjustPress && (fieldNext != watchPkg::fieldNone);
		end
	end

	assign ctl.mode = mode;
	assign ctl.field = field;
	assign ctl.adjust = adjust;

	adjustNeedsField: assert property (@(posedge clk) disable iff (rst)
		adjust |-> field != watchPkg::fieldNone);
endmodule

`default_nettype wire

//--- src/keyDebounce.sv
`timescale 1ns/1ns
`default_nettype none
`include "watch_settings.svh"

module keyDebounce (
	input logic clk,
	input logic rst,
	input logic key,
	output logic press
);
	localparam int cntWidth = $clog2(`WATCH_DEBOUNCE_TICKS + 1);

	logic [cntWidth-1:0] stableCnt;
	logic level;
	logic levelQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			stableCnt <= '0;
			level <= 1'b0;
			levelQ <= 1'b0;
			press <= 1'b0;
		end else begin
			levelQ <= level;
			press <= level & ~levelQ; // rising edge of debounced level
			if (key == level) begin
				stableCnt <= '0;
			end else if (stableCnt == cntWidth'(`WATCH_DEBOUNCE_TICKS - 1)) begin
				level <= key;
				stableCnt <= '0;
			end else begin
				stableCnt <= stableCnt + 1'b1;
			end
		end
	end

	pressIsPulse: assert property (@(posedge clk) disable iff (rst) press |=> !press);
endmodule

`default_nettype wire

//--- src/watchIf.sv
`timescale 1ns/1ns
`default_nettype none

interface watchIf;
	watchPkg::watchMode mode;
	watchPkg::setField field;
	logic adjust; // one-cycle pulse
	watchPkg::bcdTime timeNow;
	logic secTick; // one-cycle pulse
	watchPkg::bcdTime alarmTime;

	modport control (output mode, field, adjust);
	modport keeper (input mode, field, adjust, output timeNow, secTick);
	modport alarm (input mode, field, adjust, timeNow, secTick, output alarmTime);
	modport view (input mode, field, timeNow, alarmTime);
endinterface

`default_nettype wire

//--- src/displayPkg.sv
`default_nettype none

package displayPkg;
	typedef logic [7:0] segPattern; // active low, bit 7 is the dp
	typedef logic [7:0] digitSel; // active low enable per position

	localparam segPattern segDigits [0:9] = '{
		8'hc0,
		8'hf9,
		8'ha4,
		8'hb0,
		8'h99,
		8'h92,
		8'h82,
		8'hf8,
		8'h80,
		8'h90
	};

	localparam segPattern segDash = 8'hbf; // middle bar only
	localparam segPattern segBlank = 8'hff;

	localparam digitSel digitOff = 8'hff;

	// mode LEDs, active low
	localparam logic [7:0] ledTime = 8'hfe;
	localparam logic [7:0] ledAlarm = 8'hfd;
endpackage

`default_nettype wire

//--- src/watchPkg.sv
`default_nettype none

package watchPkg;
	typedef logic [3:0] bcdDigit;

	typedef struct packed {
		bcdDigit hourTens;
		bcdDigit hourOnes;
		bcdDigit minTens;
		bcdDigit minOnes;
		bcdDigit secTens;
		bcdDigit secOnes;
	} bcdTime;

	typedef enum logic {
		modeTime,
		modeAlarm
	} watchMode;

	typedef enum logic [1:0] {
		fieldNone,
		fieldSec,
		fieldMin,
		fieldHour
	} setField;

	// two BCD digits, 59 wraps to 00
	function automatic logic [7:0] incSixty(input logic [7:0] pair);
		if (pair[3:0] != 4'd9) begin
			return {pair[7:4], pair[3:0] + 4'd1};
		end else if (pair[7:4] != 4'd5) begin
			return {pair[7:4] + 4'd1, 4'd0};
		end
		return 8'h00;
	endfunction

	function automatic logic [7:0] incHour(input logic [7:0] pair);
		if (pair == 8'h23) begin
			return 8'h00;
		end else if (pair[3:0] == 4'd9) begin
			return {pair[7:4] + 4'd1, 4'd0};
		end
		return {pair[7:4], pair[3:0] + 4'd1};
	endfunction
endpackage

`default_nettype wire

//--- src/watch_settings.svh
`ifndef WATCH_SETTINGS_SVH
`define WATCH_SETTINGS_SVH

// clk cycles per watch second
`define WATCH_TICKS_PER_SEC 20

`define WATCH_DEBOUNCE_TICKS 4 // stable time before level follows
`define WATCH_BLINK_TICKS 8 // half period of blink
`define WATCH_SCAN_TICKS 1 // cycles per digit position

// ring length, counted in secTicks
`define WATCH_RING_SECONDS 5

`define WATCH_TONE_TICKS 3 // toggling part of beep pattern
`define WATCH_GAP_TICKS 2 // silent part

`endif
